// File: common/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path width
`define RV_XLEN 32

// integer register file
`define RV_NREGS 32
`define RV_REG_AW 5

// first instruction address
`define RV_RESET_PC 32'h0000_0000

`endif

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    // RV32I major opcodes in inst[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // operand a source
    typedef enum logic {
        OPA_REG = 1'b0,
        OPA_PC  = 1'b1
    } opa_sel_e;

    // operand b source
    typedef enum logic {
        OPB_REG = 1'b0,
        OPB_IMM = 1'b1
    } opb_sel_e;

endpackage

// File: common/core_ctrl_pkg.sv
package core_ctrl_pkg;

    // run/stop state of the core
    typedef enum logic {
        CORE_RUN     = 1'b0,
        CORE_STOPPED = 1'b1
    } core_state_e;

    // why the core stopped
    typedef enum logic [1:0] {
        STOP_NONE    = 2'd0,
        STOP_ECALL   = 2'd1,
        STOP_EBREAK  = 2'd2,
        STOP_ILLEGAL = 2'd3
    } stop_cause_e;

endpackage

// File: rtl/decode/inst_decode.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module inst_decode (
    input  logic                    CLK,
    input  logic                    RST_N,
    input  logic                    inst_valid,
    input  logic [31:0]             inst_code,
    output logic                    dec_valid,
    output logic [`RV_REG_AW-1:0]   rs1,
    output logic [`RV_REG_AW-1:0]   rs2,
    output logic [`RV_REG_AW-1:0]   rd,
    output logic [`RV_XLEN-1:0]     imm,
    output rv_isa_pkg::alu_op_e     alu_op,
    output rv_isa_pkg::opa_sel_e    opa_sel,
    output rv_isa_pkg::opb_sel_e    opb_sel,
    output logic                    writes_rd,
    output logic                    is_ecall,
    output logic                    is_ebreak,
    output logic                    is_unsupported
);

    rv_isa_pkg::opcode_e  opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [11:0]          funct12;
    logic                 r_type, i_type, s_type, b_type, u_type, j_type;
    logic [`RV_XLEN-1:0]  imm_d;
    rv_isa_pkg::alu_op_e  alu_op_d;
    rv_isa_pkg::opa_sel_e opa_sel_d;
    rv_isa_pkg::opb_sel_e opb_sel_d;
    logic                 ecall_d, ebreak_d, unsup_d;

    assign opcode  = rv_isa_pkg::opcode_e'(inst_code[6:0]);
    assign funct3  = inst_code[14:12];
    assign funct7  = inst_code[31:25];
    assign funct12 = inst_code[31:20];

    // instruction format
    assign r_type = opcode == rv_isa_pkg::OPC_OP;
    assign i_type = opcode == rv_isa_pkg::OPC_OP_IMM || opcode == rv_isa_pkg::OPC_LOAD ||
                    opcode == rv_isa_pkg::OPC_JALR || opcode == rv_isa_pkg::OPC_SYSTEM ||
                    opcode == rv_isa_pkg::OPC_MISC_MEM;
    assign s_type = opcode == rv_isa_pkg::OPC_STORE;
    assign b_type = opcode == rv_isa_pkg::OPC_BRANCH;
    assign u_type = opcode == rv_isa_pkg::OPC_LUI || opcode == rv_isa_pkg::OPC_AUIPC;
    assign j_type = opcode == rv_isa_pkg::OPC_JAL;

    // sign-extended immediate per format
    always_comb begin
        if (i_type) begin
            imm_d = {{20{inst_code[31]}}, inst_code[31:20]};
        end else if (s_type) begin
            imm_d = {{20{inst_code[31]}}, inst_code[31:25], inst_code[11:7]};
        end else if (b_type) begin
            imm_d = {{19{inst_code[31]}}, inst_code[31], inst_code[7],
                     inst_code[30:25], inst_code[11:8], 1'b0};
        end else if (u_type) begin
            imm_d = {inst_code[31:12], 12'h000};
        end else if (j_type) begin
            imm_d = {{11{inst_code[31]}}, inst_code[31], inst_code[19:12],
                     inst_code[20], inst_code[30:21], 1'b0};
        end else begin
            imm_d = '0;
        end
    end

    always_comb begin
        alu_op_d  = rv_isa_pkg::ALU_ADD;
        opa_sel_d = rv_isa_pkg::OPA_REG;
        opb_sel_d = rv_isa_pkg::OPB_REG;
        ecall_d   = 1'b0;
        ebreak_d  = 1'b0;
        unsup_d   = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
                if (opcode == rv_isa_pkg::OPC_OP_IMM) begin
                    opb_sel_d = rv_isa_pkg::OPB_IMM;
                end
                case (funct3)
                    3'b000: alu_op_d = (r_type && funct7[5]) ? rv_isa_pkg::ALU_SUB
                                                             : rv_isa_pkg::ALU_ADD;
                    3'b001: alu_op_d = rv_isa_pkg::ALU_SLL;
                    3'b010: alu_op_d = rv_isa_pkg::ALU_SLT;
                    3'b011: alu_op_d = rv_isa_pkg::ALU_SLTU;
                    3'b100: alu_op_d = rv_isa_pkg::ALU_XOR;
                    3'b101: alu_op_d = funct7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
                    3'b110: alu_op_d = rv_isa_pkg::ALU_OR;
                    default: alu_op_d = rv_isa_pkg::ALU_AND;
                endcase
                // funct7 is only a real field for OP and the shift immediates
                if (r_type || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct7 == 7'b0100000) begin
                        unsup_d = !(funct3 == 3'b101 || (r_type && funct3 == 3'b000));
                    end else begin
                        unsup_d = funct7 != 7'b0000000;
                    end
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                alu_op_d  = rv_isa_pkg::ALU_PASS_B;
                opb_sel_d = rv_isa_pkg::OPB_IMM;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                opa_sel_d = rv_isa_pkg::OPA_PC;
                opb_sel_d = rv_isa_pkg::OPB_IMM;
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                ecall_d  = funct3 == 3'b000 && funct12 == 12'h000;
                ebreak_d = funct3 == 3'b000 && funct12 == 12'h001;
                unsup_d  = !(ecall_d || ebreak_d);
            end
            default: unsup_d = 1'b1;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            dec_valid      <= 1'b0;
            writes_rd      <= 1'b0;
            is_ecall       <= 1'b0;
            is_ebreak      <= 1'b0;
            is_unsupported <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
            if (inst_valid) begin
                writes_rd      <= r_type | i_type | u_type | j_type;
                is_ecall       <= ecall_d;
                is_ebreak      <= ebreak_d;
                is_unsupported <= unsup_d;
            end
        end
    end

    // unused operand fields read as register 0
    always_ff @(posedge CLK) begin
        if (inst_valid) begin
            rs1     <= (r_type | i_type | s_type | b_type) ? inst_code[19:15] : '0;
            rs2     <= (r_type | s_type | b_type) ? inst_code[24:20] : '0;
            rd      <= inst_code[11:7];
            imm     <= imm_d;
            alu_op  <= alu_op_d;
            opa_sel <= opa_sel_d;
            opb_sel <= opb_sel_d;
        end
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module regfile (
    input  logic                  CLK,
    input  logic                  RST_N,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] wa,
    input  logic [`RV_XLEN-1:0]   wd,
    output logic [`RV_XLEN-1:0]   rd1,
    output logic [`RV_XLEN-1:0]   rd2
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module alu (
    input  rv_isa_pkg::alu_op_e  alu_op,
    input  rv_isa_pkg::opa_sel_e opa_sel,
    input  rv_isa_pkg::opb_sel_e opb_sel,
    input  logic [`RV_XLEN-1:0]  rs1_data,
    input  logic [`RV_XLEN-1:0]  rs2_data,
    input  logic [`RV_XLEN-1:0]  imm,
    input  logic [`RV_XLEN-1:0]  pc,
    output logic [`RV_XLEN-1:0]  result
);

    logic [`RV_XLEN-1:0] opa;
    logic [`RV_XLEN-1:0] opb;
    logic [4:0]          shamt;
    logic                lt_signed;
    logic                lt_unsigned;

    assign opa = (opa_sel == rv_isa_pkg::OPA_PC) ? pc : rs1_data;
    assign opb = (opb_sel == rv_isa_pkg::OPB_IMM) ? imm : rs2_data;

    // shifts use only the low 5 bits
    assign shamt = opb[4:0];

    assign lt_signed   = $signed(opa) < $signed(opb);
    assign lt_unsigned = opa < opb;

    always_comb begin
        case (alu_op)
            rv_isa_pkg::ALU_ADD:    result = opa + opb;
            rv_isa_pkg::ALU_SUB:    result = opa - opb;
            rv_isa_pkg::ALU_SLL:    result = opa << shamt;
            rv_isa_pkg::ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            rv_isa_pkg::ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            rv_isa_pkg::ALU_XOR:    result = opa ^ opb;
            rv_isa_pkg::ALU_SRL:    result = opa >> shamt;
            rv_isa_pkg::ALU_SRA:    result = $unsigned($signed(opa) >>> shamt);
            rv_isa_pkg::ALU_OR:     result = opa | opb;
            rv_isa_pkg::ALU_AND:    result = opa & opb;
            rv_isa_pkg::ALU_PASS_B: result = opb;
            default:                result = '0;
        endcase
    end

endmodule

// File: rtl/issue_ctrl.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module issue_ctrl (
    input  logic                        CLK,
    input  logic                        RST_N,
    input  logic                        dec_valid,
    input  logic [`RV_REG_AW-1:0]       rd,
    input  logic                        writes_rd,
    input  logic                        is_ecall,
    input  logic                        is_ebreak,
    input  logic                        is_unsupported,
    input  logic [`RV_XLEN-1:0]         result,
    output logic [`RV_XLEN-1:0]         pc,
    output logic                        rf_we,
    output logic [`RV_REG_AW-1:0]       rf_wa,
    output logic [`RV_XLEN-1:0]         rf_wd,
    output logic                        wb_valid,
    output logic [`RV_REG_AW-1:0]       wb_rd,
    output logic [`RV_XLEN-1:0]         wb_data,
    output logic                        stopped,
    output core_ctrl_pkg::stop_cause_e  stop_cause
);

    core_ctrl_pkg::core_state_e state;
    logic                       running;
    logic                       stop_req;
    logic                       exec;

    assign running  = state == core_ctrl_pkg::CORE_RUN;
    assign stop_req = dec_valid && running && (is_ecall || is_ebreak || is_unsupported);
    assign exec     = dec_valid && running && !stop_req;

    // write request for this edge
    assign rf_we = exec && writes_rd && rd != '0;
    assign rf_wa = rd;
    assign rf_wd = result;

    assign stopped = state == core_ctrl_pkg::CORE_STOPPED;

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            state      <= core_ctrl_pkg::CORE_RUN;
            stop_cause <= core_ctrl_pkg::STOP_NONE;
            pc         <= `RV_RESET_PC;
            wb_valid   <= 1'b0;
        end else begin
            wb_valid <= rf_we;
            if (exec) begin
                pc <= pc + `RV_XLEN'(4);
            end
            // first stop cause is kept until reset
            if (stop_req) begin
                state <= core_ctrl_pkg::CORE_STOPPED;
                if (is_unsupported) begin
                    stop_cause <= core_ctrl_pkg::STOP_ILLEGAL;
                end else if (is_ecall) begin
                    stop_cause <= core_ctrl_pkg::STOP_ECALL;
                end else begin
                    stop_cause <= core_ctrl_pkg::STOP_EBREAK;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rf_we) begin
            wb_rd   <= rf_wa;
            wb_data <= rf_wd;
        end
    end

endmodule

// File: rtl/core_top.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module core_top (
    input  logic                        CLK,
    input  logic                        RST_N,
    input  logic                        inst_valid,
    input  logic [31:0]                 inst_code,
    output logic                        wb_valid,
    output logic [`RV_REG_AW-1:0]       wb_rd,
    output logic [`RV_XLEN-1:0]         wb_data,
    output logic                        stopped,
    output core_ctrl_pkg::stop_cause_e  stop_cause
);

    logic                   dec_valid;
    logic [`RV_REG_AW-1:0]  rs1, rs2, rd;
    logic [`RV_XLEN-1:0]    imm;
    rv_isa_pkg::alu_op_e    alu_op;
    rv_isa_pkg::opa_sel_e   opa_sel;
    rv_isa_pkg::opb_sel_e   opb_sel;
    logic                   writes_rd;
    logic                   is_ecall, is_ebreak, is_unsupported;
    logic [`RV_XLEN-1:0]    rs1_data, rs2_data;
    logic [`RV_XLEN-1:0]    result;
    logic [`RV_XLEN-1:0]    pc;
    logic                   rf_we;
    logic [`RV_REG_AW-1:0]  rf_wa;
    logic [`RV_XLEN-1:0]    rf_wd;

    inst_decode decode_i (
        .CLK(CLK), .RST_N(RST_N),
        .inst_valid(inst_valid), .inst_code(inst_code),
        .dec_valid(dec_valid),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .alu_op(alu_op), .opa_sel(opa_sel), .opb_sel(opb_sel),
        .writes_rd(writes_rd),
        .is_ecall(is_ecall), .is_ebreak(is_ebreak), .is_unsupported(is_unsupported)
    );

    regfile regfile_i (
        .CLK(CLK), .RST_N(RST_N),
        .rs1(rs1), .rs2(rs2),
        .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .rd1(rs1_data), .rd2(rs2_data)
    );

    alu alu_i (
        .alu_op(alu_op), .opa_sel(opa_sel), .opb_sel(opb_sel),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm(imm), .pc(pc),
        .result(result)
    );

    issue_ctrl ctrl_i (
        .CLK(CLK), .RST_N(RST_N),
        .dec_valid(dec_valid), .rd(rd), .writes_rd(writes_rd),
        .is_ecall(is_ecall), .is_ebreak(is_ebreak), .is_unsupported(is_unsupported),
        .result(result), .pc(pc),
        .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .stopped(stopped), .stop_cause(stop_cause)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int RST_CYCLES = 10
) (
    input  logic restart,
    output logic CLK,
    output logic RST_N
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // reset at start and again on every restart request
    initial begin
        RST_N = 1'b0;
        forever begin
            repeat (RST_CYCLES) @(negedge CLK);
            RST_N = 1'b1;
            @(posedge restart);
            RST_N = 1'b0;
        end
    end

endmodule

// File: test/tb_checker.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_checker (
    input  logic                       CLK,
    input  logic                       RST_N,
    input  logic                       inst_valid,
    input  logic [31:0]                inst_code,
    input  logic                       exp_wb,
    input  logic [`RV_REG_AW-1:0]      exp_rd,
    input  logic [`RV_XLEN-1:0]        exp_data,
    input  core_ctrl_pkg::stop_cause_e exp_stop,
    input  logic                       wb_valid,
    input  logic [`RV_REG_AW-1:0]      wb_rd,
    input  logic [`RV_XLEN-1:0]        wb_data,
    input  logic                       stopped,
    input  core_ctrl_pkg::stop_cause_e stop_cause,
    output int                         checked,
    output int                         errors
);

    typedef struct packed {
        logic [31:0]                code;
        logic                       wb;
        logic [`RV_REG_AW-1:0]      rd;
        logic [`RV_XLEN-1:0]        data;
        core_ctrl_pkg::stop_cause_e stop;
        logic [31:0]                due;
    } pending_t;

    pending_t    pending [$];
    logic [31:0] edge_cnt = 0;
    int          n_checked = 0;
    int          n_errors = 0;

    assign checked = n_checked;
    assign errors  = n_errors;

    // result is registered one edge after the sampling edge
    always @(posedge CLK) begin
        edge_cnt = edge_cnt + 1;
        if (RST_N && inst_valid) begin
            pending.push_back({inst_code, exp_wb, exp_rd, exp_data, exp_stop, edge_cnt + 1});
        end
    end

    always @(negedge CLK) begin
        pending_t head;
        logic     ok;
        if (!RST_N) begin
            pending.delete();
        end else if (pending.size() > 0 && pending[0].due == edge_cnt) begin
            head = pending.pop_front();
            ok = 1'b1;
            if (head.wb && !wb_valid) begin
                $display("ERROR at %0t: expected write of x%0d not seen two edges after its strobe",
                         $time, head.rd);
                ok = 1'b0;
            end else if (!head.wb && wb_valid) begin
                $display("ERROR at %0t: writeback to x%0d where none was expected",
                         $time, wb_rd);
                ok = 1'b0;
            end else if (head.wb) begin
                if (wb_rd !== head.rd) begin
                    $display("MISMATCH at %0t: wb_rd got %0d expected %0d", $time, wb_rd, head.rd);
                    ok = 1'b0;
                end
                if (wb_data !== head.data) begin
                    $display("MISMATCH at %0t: wb_data got %08h expected %08h",
                             $time, wb_data, head.data);
                    ok = 1'b0;
                end
            end
            if (stop_cause !== head.stop) begin
                $display("MISMATCH at %0t: stop_cause got %0d expected %0d",
                         $time, stop_cause, head.stop);
                ok = 1'b0;
            end
            if (stopped !== (head.stop != core_ctrl_pkg::STOP_NONE)) begin
                $display("MISMATCH at %0t: stopped got %0b expected %0b",
                         $time, stopped, head.stop != core_ctrl_pkg::STOP_NONE);
                ok = 1'b0;
            end
            n_checked = n_checked + 1;
            if (!ok) begin
                n_errors = n_errors + 1;
            end
            $display("[%0d] inst %08h %s", n_checked, head.code, ok ? "ok" : "error");
        end else if (wb_valid) begin
            $display("ERROR at %0t: writeback to x%0d with no instruction due", $time, wb_rd);
            n_errors = n_errors + 1;
        end
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_top;

    localparam int MAX_GAP = 3;
    localparam int RUNS = 4;
    localparam logic [6:0] OPR = rv_isa_pkg::OPC_OP;
    localparam logic [6:0] OPI = rv_isa_pkg::OPC_OP_IMM;
    localparam logic [6:0] LUI_OP = rv_isa_pkg::OPC_LUI;
    localparam logic [6:0] AUI_OP = rv_isa_pkg::OPC_AUIPC;
    localparam logic [6:0] STO = rv_isa_pkg::OPC_STORE;
    localparam core_ctrl_pkg::stop_cause_e ST_N = core_ctrl_pkg::STOP_NONE;
    localparam core_ctrl_pkg::stop_cause_e ST_EC = core_ctrl_pkg::STOP_ECALL;
    localparam core_ctrl_pkg::stop_cause_e ST_EB = core_ctrl_pkg::STOP_EBREAK;
    localparam core_ctrl_pkg::stop_cause_e ST_IL = core_ctrl_pkg::STOP_ILLEGAL;

    typedef struct packed {
        logic                       new_run;
        logic [31:0]                code;
        logic                       wb;
        logic [`RV_REG_AW-1:0]      rd;
        logic [`RV_XLEN-1:0]        data;
        core_ctrl_pkg::stop_cause_e stop;
    } entry_t;

    logic                       CLK;
    logic                       RST_N;
    logic                       restart = 1'b0;
    logic                       inst_valid = 1'b0;
    logic [31:0]                inst_code = '0;
    logic                       exp_wb = 1'b0;
    logic [`RV_REG_AW-1:0]      exp_rd = '0;
    logic [`RV_XLEN-1:0]        exp_data = '0;
    core_ctrl_pkg::stop_cause_e exp_stop = core_ctrl_pkg::STOP_NONE;
    logic                       wb_valid;
    logic [`RV_REG_AW-1:0]      wb_rd;
    logic [`RV_XLEN-1:0]        wb_data;
    logic                       stopped;
    core_ctrl_pkg::stop_cause_e stop_cause;
    int                         checked;
    int                         errors;
    entry_t                     tab [$];
    integer                     seed = 23570;
    int                         cycles = 0;
    int                         limit = 0;

    tb_clock #(.RST_CYCLES(10)) clock_i (.restart(restart), .CLK(CLK), .RST_N(RST_N));

    core_top dut_i (
        .CLK(CLK), .RST_N(RST_N),
        .inst_valid(inst_valid), .inst_code(inst_code),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .stopped(stopped), .stop_cause(stop_cause)
    );

    tb_checker checker_i (
        .CLK(CLK), .RST_N(RST_N),
        .inst_valid(inst_valid), .inst_code(inst_code),
        .exp_wb(exp_wb), .exp_rd(exp_rd), .exp_data(exp_data), .exp_stop(exp_stop),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .stopped(stopped), .stop_cause(stop_cause),
        .checked(checked), .errors(errors)
    );

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic add_vec(input logic new_run, input logic [31:0] code, input logic wb,
                           input logic [4:0] rd, input logic [31:0] data,
                           input core_ctrl_pkg::stop_cause_e stop);
        tab.push_back({new_run, code, wb, rd, data, stop});
    endtask

    task automatic build_table();
        // immediate ops from zeroed registers
        add_vec(0, i_word(12'hffb, 0, 3'b000, 1, OPI), 1, 1, 32'hffff_fffb, ST_N);
        add_vec(0, i_word(12'd100, 0, 3'b000, 2, OPI), 1, 2, 32'h0000_0064, ST_N);
        add_vec(0, i_word(12'hffc, 1, 3'b010, 3, OPI), 1, 3, 32'h0000_0001, ST_N);
        add_vec(0, i_word(12'h007, 1, 3'b011, 4, OPI), 1, 4, 32'h0000_0000, ST_N);
        add_vec(0, i_word(12'h0f0, 1, 3'b100, 5, OPI), 1, 5, 32'hffff_ff0b, ST_N);
        add_vec(0, i_word(12'hf00, 2, 3'b110, 6, OPI), 1, 6, 32'hffff_ff64, ST_N);
        add_vec(0, i_word(12'h7ff, 1, 3'b111, 7, OPI), 1, 7, 32'h0000_07fb, ST_N);
        // dependent register-register chain
        add_vec(0, r_word(7'h00, 2, 1, 3'b000, 8, OPR), 1, 8, 32'h0000_005f, ST_N);
        add_vec(0, r_word(7'h20, 2, 8, 3'b000, 9, OPR), 1, 9, 32'hffff_fffb, ST_N);
        add_vec(0, r_word(7'h00, 3, 9, 3'b001, 10, OPR), 1, 10, 32'hffff_fff6, ST_N);
        add_vec(0, r_word(7'h00, 8, 10, 3'b010, 11, OPR), 1, 11, 32'h0000_0001, ST_N);
        add_vec(0, r_word(7'h00, 8, 10, 3'b011, 12, OPR), 1, 12, 32'h0000_0000, ST_N);
        add_vec(0, r_word(7'h00, 2, 10, 3'b100, 13, OPR), 1, 13, 32'hffff_ff92, ST_N);
        add_vec(0, r_word(7'h00, 11, 13, 3'b101, 14, OPR), 1, 14, 32'h7fff_ffc9, ST_N);
        add_vec(0, r_word(7'h20, 11, 13, 3'b101, 15, OPR), 1, 15, 32'hffff_ffc9, ST_N);
        add_vec(0, r_word(7'h00, 2, 14, 3'b110, 16, OPR), 1, 16, 32'h7fff_ffed, ST_N);
        add_vec(0, r_word(7'h00, 5, 16, 3'b111, 17, OPR), 1, 17, 32'h7fff_ff09, ST_N);
        // auipc here is the 19th instruction at pc 0x48
        add_vec(0, u_word(20'h12345, 18, LUI_OP), 1, 18, 32'h1234_5000, ST_N);
        add_vec(0, u_word(20'h00001, 19, AUI_OP), 1, 19, `RV_RESET_PC + 32'h0000_1048, ST_N);
        add_vec(0, i_word(12'd123, 0, 3'b000, 0, OPI), 0, 0, 32'h0, ST_N);
        add_vec(0, r_word(7'h00, 2, 1, 3'b000, 0, OPR), 0, 0, 32'h0, ST_N);
        add_vec(0, r_word(7'h00, 2, 0, 3'b000, 20, OPR), 1, 20, 32'h0000_0064, ST_N);
        add_vec(0, i_word(12'h004, 2, 3'b001, 21, OPI), 1, 21, 32'h0000_0640, ST_N);
        add_vec(0, i_word(12'h01c, 1, 3'b101, 22, OPI), 1, 22, 32'h0000_000f, ST_N);
        add_vec(0, i_word(12'h401, 1, 3'b101, 23, OPI), 1, 23, 32'hffff_fffd, ST_N);
        add_vec(0, u_word(20'h00000, 24, AUI_OP), 1, 24, `RV_RESET_PC + 32'h0000_0064, ST_N);
        // slli with funct7 0100000
        add_vec(0, i_word(12'h404, 2, 3'b001, 25, OPI), 0, 0, 32'h0, ST_IL);
        add_vec(0, i_word(12'h001, 0, 3'b000, 25, OPI), 0, 0, 32'h0, ST_IL);
        // x5 from the first run reads zero after reset
        add_vec(1, i_word(12'h007, 5, 3'b000, 1, OPI), 1, 1, 32'h0000_0007, ST_N);
        add_vec(0, 32'h0000_0073, 0, 0, 32'h0, ST_EC);
        add_vec(0, i_word(12'h009, 0, 3'b000, 2, OPI), 0, 0, 32'h0, ST_EC);
        // pc restarts at the reset value
        add_vec(1, u_word(20'h00000, 1, AUI_OP), 1, 1, `RV_RESET_PC, ST_N);
        add_vec(0, 32'h0010_0073, 0, 0, 32'h0, ST_EB);
        add_vec(0, r_word(7'h00, 1, 1, 3'b000, 3, OPR), 0, 0, 32'h0, ST_EB);
        // sw x5, 0(x0)
        add_vec(1, u_word(20'habcde, 5, LUI_OP), 1, 5, 32'habcd_e000, ST_N);
        add_vec(0, r_word(7'h00, 5, 0, 3'b010, 0, STO), 0, 0, 32'h0, ST_IL);
        add_vec(0, i_word(12'h003, 0, 3'b000, 6, OPI), 0, 0, 32'h0, ST_IL);
    endtask

    task automatic apply_entry(input entry_t e);
        inst_valid = 1'b1;
        inst_code  = e.code;
        exp_wb     = e.wb;
        exp_rd     = e.rd;
        exp_data   = e.data;
        exp_stop   = e.stop;
    endtask

    // drain the pipe and pulse reset for a fresh run
    task automatic reset_core();
        repeat (4) @(negedge CLK);
        restart = 1'b1;
        @(negedge CLK);
        restart = 1'b0;
        wait (RST_N === 1'b1);
    endtask

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int gap;
        build_table();
        limit = tab.size() * (MAX_GAP + 1) + RUNS * 16 + 50;
        wait (RST_N === 1'b1);
        for (int i = 0; i < tab.size(); i++) begin
            if (tab[i].new_run) begin
                inst_valid = 1'b0;
                reset_core();
            end
            apply_entry(tab[i]);
            @(negedge CLK);
            gap = (i % 2 == 1) ? 0 : $unsigned($random(seed)) % (MAX_GAP + 1);
            if (gap > 0) begin
                inst_valid = 1'b0;
                repeat (gap) @(negedge CLK);
            end
        end
        inst_valid = 1'b0;
        repeat (4) @(negedge CLK);
        $display("%0d of %0d instructions checked, %0d errors", checked, tab.size(), errors);
        if (errors == 0 && checked == tab.size()) begin
            $display("TEST PASS");
        end else begin
            if (checked != tab.size()) begin
                $display("not every instruction reached its check");
            end
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+common
common/rv_isa_pkg.sv
common/core_ctrl_pkg.sv
rtl/decode/inst_decode.sv
rtl/regfile.sv
rtl/alu.sv
rtl/issue_ctrl.sv
rtl/core_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the core slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f sources.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log

# the simulation exits cleanly either way, the log decides
grep -q "TEST PASS" sim.log
